// ==== files.f ====
+incdir+.
isa_pkg.sv
rob_pkg.sv
dispatch_stage.sv
alu_lane.sv
reorder_buffer.sv
ooo_core.sv
tb_clock_gen.sv
ooo_core_tb.sv

// ==== ooo_core_tb.sv ====
////////////////////
// testbench for the dispatch-to-commit core
// random two-slot traffic against a queue model,
// halt and illegal stop behavior
////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "core_defs.svh"

module ooo_core_tb;
	import isa_pkg::*;
	import rob_pkg::*;

	localparam int period_ns     = 40;
	localparam int reset_cycles  = 3;
	localparam int random_groups = 150;
	localparam int phase_slack   = 20;
	// worst case about three cycles per group under back-pressure
	localparam int planned_cycles = 2 * reset_cycles + 3 * random_groups + 4 * phase_slack;

	logic por_reset;
	logic restart;
	logic clock;
	logic reset;

	// DUT inputs
	logic     [`CORE_WAYS-1:0] slot_valid;
	op_t      [`CORE_WAYS-1:0] slot_op;
	data_t    [`CORE_WAYS-1:0] slot_a;
	data_t    [`CORE_WAYS-1:0] slot_b;
	reg_idx_t [`CORE_WAYS-1:0] slot_dest;

	// DUT outputs
	logic                      stall;
	logic     [`CORE_WAYS-1:0] commit_valid;
	reg_idx_t [`CORE_WAYS-1:0] commit_reg;
	data_t    [`CORE_WAYS-1:0] commit_data;
	logic     [`CORE_WAYS-1:0] commit_wr_en;
	commit_count_t             completed_insts;
	error_status_t             error_status;

	// model of outstanding entries, oldest first
	op_t      q_op[$];
	reg_idx_t q_dest[$];
	data_t    q_data[$];
	int       q_accept_edge[$];
	bit       q_into_empty[$];

	int            cycle = 0;
	int            accepted_total;
	int            committed_total;
	int            completed_sum;
	int            stall_cycles;
	bit            slot_taken;
	error_status_t model_status;
	logic [31:0]   rand_state = 32'h3ccc_a10d;

	// power-on reset or a later restart
	assign reset = por_reset | restart;

	tb_clock_gen #(
		.period_ns    (period_ns),
		.reset_cycles (reset_cycles)
	) clock_gen_i (
		.clock (clock),
		.reset (por_reset)
	);

	ooo_core dut_i (
		.clock           (clock),
		.reset           (reset),
		.slot_valid      (slot_valid),
		.slot_op         (slot_op),
		.slot_a          (slot_a),
		.slot_b          (slot_b),
		.slot_dest       (slot_dest),
		.stall           (stall),
		.commit_valid    (commit_valid),
		.commit_reg      (commit_reg),
		.commit_data     (commit_data),
		.commit_wr_en    (commit_wr_en),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

	////////////////////
	// helpers
	////////////////////
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else
			stop_on_error($sformatf("error: %s is %h, expected %h", name, got, exp));
	endtask

	task automatic check_true(input bit cond, input string msg);
		assert (cond) else stop_on_error(msg);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// op rules straight from the ISA description
	function automatic data_t expected_result(input op_t op, input data_t a, input data_t b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << b[4:0];
			default: return '0;
		endcase
	endfunction

	// normal ops only, both slots valid when full is set
	task automatic randomize_slots(input bit full);
		logic [31:0] r;
		for (int i = 0; i < `CORE_WAYS; i++) begin
			rand_state = xorshift32(rand_state);
			r = rand_state;
			slot_op[i] = op_t'(r[7:0] % 8'd6);
			slot_dest[i] = reg_idx_t'(r[12:8]);
			rand_state = xorshift32(rand_state);
			slot_a[i] = rand_state;
			rand_state = xorshift32(rand_state);
			slot_b[i] = rand_state;
		end
		rand_state = xorshift32(rand_state);
		if (full || rand_state[3:0] != 4'h0) begin
			slot_valid = '1;
		end else begin
			slot_valid = rand_state[5:4];
		end
	endtask

	task automatic idle_slots();
		slot_valid = '0;
	endtask

	// inputs change just after the rising edge
	task automatic next_drive_point();
		@(posedge clock);
		#1;
	endtask

	// hold the current slots until an edge accepts them
	task automatic wait_taken();
		do begin
			next_drive_point();
		end while (!slot_taken);
	endtask

	task automatic wait_drained();
		while (q_op.size() != 0) begin
			next_drive_point();
		end
	endtask

	////////////////////
	// commit and stall checks
	////////////////////
	task automatic check_commits();
		int       latency;
		op_t      op;
		reg_idx_t dest;
		data_t    data;
		bit       into_empty;
		logic     exp_wr;
		check_true(!(commit_valid[1] && !commit_valid[0]),
			"commit on lane 1 without lane 0 breaks program order");
		check_value("completed_insts", completed_insts,
			32'(commit_valid[0]) + 32'(commit_valid[1]));
		for (int i = 0; i < `CORE_WAYS; i++) begin
			if (commit_valid[i]) begin
				check_true(model_status == NO_ERROR, "commit seen after the core stopped");
				check_true(q_op.size() != 0, "commit seen with nothing outstanding");
				op = q_op.pop_front();
				dest = q_dest.pop_front();
				data = q_data.pop_front();
				latency = cycle - q_accept_edge.pop_front();
				into_empty = q_into_empty.pop_front();
				// nothing older to wait for, so the pipeline depth alone
				if (into_empty) begin
					check_value("commit latency", latency, 3);
				end else begin
					check_true(latency >= 3, "commit came sooner than three cycles after accept");
				end
				exp_wr = op != OP_HALT && op != OP_ILLEGAL && dest != '0;
				check_value($sformatf("commit_reg[%0d]", i), commit_reg[i], dest);
				check_value($sformatf("commit_data[%0d]", i), commit_data[i], data);
				check_value($sformatf("commit_wr_en[%0d]", i), commit_wr_en[i], exp_wr);
				if (op == OP_HALT) begin
					model_status = HALTED_ON_WFI;
				end else if (op == OP_ILLEGAL) begin
					model_status = ILLEGAL_INST;
				end
				committed_total++;
			end
		end
		check_value("error_status", error_status, model_status);
		completed_sum += completed_insts;
	endtask

	task automatic record_accepts();
		bit empty;
		empty = accepted_total == committed_total;
		slot_taken = !stall;
		if (!stall) begin
			for (int i = 0; i < `CORE_WAYS; i++) begin
				if (slot_valid[i]) begin
					q_op.push_back(slot_op[i]);
					q_dest.push_back(slot_dest[i]);
					q_data.push_back(expected_result(slot_op[i], slot_a[i], slot_b[i]));
					q_accept_edge.push_back(cycle + 1);
					q_into_empty.push_back(empty);
					accepted_total++;
				end
			end
		end
	endtask

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// everything is stable at the falling edge
	always @(negedge clock) begin
		if (reset) begin
			q_op.delete();
			q_dest.delete();
			q_data.delete();
			q_accept_edge.delete();
			q_into_empty.delete();
			accepted_total  = 0;
			committed_total = 0;
			completed_sum   = 0;
			stall_cycles    = 0;
			slot_taken      = 1'b0;
			model_status    = NO_ERROR;
		end else begin
			check_commits();
			// free count seen by dispatch after this edge
			check_value("stall", stall,
				(`ROB_DEPTH - (accepted_total - committed_total)) < `CORE_WAYS);
			if (stall) begin
				stall_cycles++;
			end
			record_accepts();
		end
	end

	// once stopped, the commit ports stay quiet
	assert property (@(posedge clock) disable iff (reset)
		error_status != NO_ERROR |=> commit_valid == '0)
	else stop_on_error($sformatf("error: commit_valid is %h after the core stopped, expected 0",
		commit_valid));

	initial begin
		#(planned_cycles * 2 * period_ns);
		stop_on_error("timeout: the run did not finish within the planned time");
	end

	////////////////////
	// test sequence
	////////////////////
	initial begin
		int groups;
		restart = 1'b0;
		slot_valid = '0;
		for (int i = 0; i < `CORE_WAYS; i++) begin
			slot_op[i]   = OP_ADD;
			slot_a[i]    = '0;
			slot_b[i]    = '0;
			slot_dest[i] = '0;
		end
		@(negedge reset);
		@(posedge clock);
		@(negedge clock);
		// state right after reset
		check_value("stall", stall, 0);
		check_value("commit_valid", commit_valid, 0);
		check_value("completed_insts", completed_insts, 0);
		check_value("error_status", error_status, NO_ERROR);

		// lone slot into an empty core
		next_drive_point();
		slot_valid   = 2'b01;
		slot_op[0]   = OP_ADD;
		slot_a[0]    = 32'h1234_5678;
		slot_b[0]    = 32'h0fed_cba9;
		slot_dest[0] = 5'd4;
		wait_taken();
		idle_slots();
		wait_drained();

		// back-to-back traffic
		for (groups = 0; groups < random_groups; groups++) begin
			randomize_slots(1'b0);
			wait_taken();
		end
		idle_slots();
		wait_drained();
		check_value("completed_insts sum", completed_sum, accepted_total);
		check_true(stall_cycles > 0, "back-to-back traffic never raised stall");

		// halt, then keep offering slots until the buffer fills
		randomize_slots(1'b1);
		slot_op[0] = OP_HALT;
		for (groups = 0; groups < 12 && !stall; groups++) begin
			next_drive_point();
			if (slot_taken) begin
				randomize_slots(1'b1);
			end
		end
		check_true(stall, "stall did not rise after the halt filled the reorder buffer");
		repeat (8) next_drive_point();
		check_value("stall", stall, 1);
		check_value("error_status", error_status, HALTED_ON_WFI);

		// fresh reset, then an illegal slot
		restart = 1'b1;
		idle_slots();
		repeat (reset_cycles) next_drive_point();
		restart = 1'b0;
		slot_valid   = 2'b01;
		slot_op[0]   = OP_ILLEGAL;
		slot_dest[0] = 5'd9;
		wait_taken();
		idle_slots();
		wait_drained();
		repeat (4) next_drive_point();
		check_value("error_status", error_status, ILLEGAL_INST);

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
////////////////////
// testbench clock and power-on reset
////////////////////

`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int period_ns    = 40,
	parameter int reset_cycles = 3
) (
	output logic clock,
	output logic reset
);

	// free-running clock, first rising edge at half a period
	initial begin
		clock = 1'b0;
		forever #(period_ns / 2) clock = ~clock;
	end

	// reset over the first few rising edges, released just after one
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== ooo_core.sv ====
////////////////////
// dispatch-to-commit core
// dispatch stage, ALU lanes on the CDB, reorder buffer
////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "core_defs.svh"

module ooo_core (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic          [`CORE_WAYS-1:0]        slot_valid,
	input  isa_pkg::op_t  [`CORE_WAYS-1:0]        slot_op,
	input  isa_pkg::data_t [`CORE_WAYS-1:0]       slot_a,
	input  isa_pkg::data_t [`CORE_WAYS-1:0]       slot_b,
	input  isa_pkg::reg_idx_t [`CORE_WAYS-1:0]    slot_dest,
	output logic                                  stall,
	output logic          [`CORE_WAYS-1:0]        commit_valid,
	output isa_pkg::reg_idx_t [`CORE_WAYS-1:0]    commit_reg,
	output isa_pkg::data_t [`CORE_WAYS-1:0]       commit_data,
	output logic          [`CORE_WAYS-1:0]        commit_wr_en,
	output rob_pkg::commit_count_t                completed_insts,
	output rob_pkg::error_status_t                error_status
);
	import isa_pkg::*;
	import rob_pkg::*;

	// dispatch to lanes and reorder buffer
	logic              [`CORE_WAYS-1:0] disp_valid;
	op_t               [`CORE_WAYS-1:0] disp_op;
	data_t             [`CORE_WAYS-1:0] disp_a;
	data_t             [`CORE_WAYS-1:0] disp_b;
	reg_idx_t          [`CORE_WAYS-1:0] disp_dest;
	rob_idx_t          [`CORE_WAYS-1:0] disp_rob_idx;

	// CDB, one lane per ALU
	logic              [`CORE_WAYS-1:0] cdb_valid;
	rob_idx_t          [`CORE_WAYS-1:0] cdb_rob_idx;
	data_t             [`CORE_WAYS-1:0] cdb_data;

	// entries freed this cycle
	commit_count_t num_committed;

	dispatch_stage dispatch_i (
		.clock         (clock),
		.reset         (reset),
		.slot_valid    (slot_valid),
		.slot_op       (slot_op),
		.slot_a        (slot_a),
		.slot_b        (slot_b),
		.slot_dest     (slot_dest),
		.num_committed (num_committed),
		.stall         (stall),
		.disp_valid    (disp_valid),
		.disp_op       (disp_op),
		.disp_a        (disp_a),
		.disp_b        (disp_b),
		.disp_dest     (disp_dest),
		.disp_rob_idx  (disp_rob_idx)
	);

	// lane i serves slot i
	for (genvar i = 0; i < `CORE_WAYS; i++) begin : g_lane
		alu_lane lane_i (
			.clock        (clock),
			.reset        (reset),
			.disp_valid   (disp_valid[i]),
			.disp_op      (disp_op[i]),
			.disp_a       (disp_a[i]),
			.disp_b       (disp_b[i]),
			.disp_rob_idx (disp_rob_idx[i]),
			.cdb_valid    (cdb_valid[i]),
			.cdb_rob_idx  (cdb_rob_idx[i]),
			.cdb_data     (cdb_data[i])
		);
	end

	reorder_buffer rob_i (
		.clock           (clock),
		.reset           (reset),
		.disp_valid      (disp_valid),
		.disp_op         (disp_op),
		.disp_dest       (disp_dest),
		.disp_rob_idx    (disp_rob_idx),
		.cdb_valid       (cdb_valid),
		.cdb_rob_idx     (cdb_rob_idx),
		.cdb_data        (cdb_data),
		.num_committed   (num_committed),
		.commit_valid    (commit_valid),
		.commit_reg      (commit_reg),
		.commit_data     (commit_data),
		.commit_wr_en    (commit_wr_en),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
////////////////////
// reorder buffer
// holds dispatched entries, marks them done from the CDB,
// retires up to two per cycle in order and reports status
////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "core_defs.svh"

module reorder_buffer (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic          [`CORE_WAYS-1:0]        disp_valid,
	input  isa_pkg::op_t  [`CORE_WAYS-1:0]        disp_op,
	input  isa_pkg::reg_idx_t [`CORE_WAYS-1:0]    disp_dest,
	input  rob_pkg::rob_idx_t [`CORE_WAYS-1:0]    disp_rob_idx,
	input  logic          [`CORE_WAYS-1:0]        cdb_valid,
	input  rob_pkg::rob_idx_t [`CORE_WAYS-1:0]    cdb_rob_idx,
	input  isa_pkg::data_t [`CORE_WAYS-1:0]       cdb_data,
	output rob_pkg::commit_count_t                num_committed,
	output logic          [`CORE_WAYS-1:0]        commit_valid,
	output isa_pkg::reg_idx_t [`CORE_WAYS-1:0]    commit_reg,
	output isa_pkg::data_t [`CORE_WAYS-1:0]       commit_data,
	output logic          [`CORE_WAYS-1:0]        commit_wr_en,
	output rob_pkg::commit_count_t                completed_insts,
	output rob_pkg::error_status_t                error_status
);
	import isa_pkg::*;
	import rob_pkg::*;

	// what retiring an entry means
	typedef enum logic [1:0] {
		CLASS_NORMAL  = 2'd0,
		CLASS_HALT    = 2'd1,
		CLASS_ILLEGAL = 2'd2
	} op_class_t;

	////////////////////
	// entry storage
	////////////////////
	logic      [`ROB_DEPTH-1:0] entry_done;
	reg_idx_t  entry_dest   [`ROB_DEPTH];
	op_class_t entry_class  [`ROB_DEPTH];
	data_t     entry_result [`ROB_DEPTH];

	// oldest entry
	rob_idx_t head;

	// per commit lane
	rob_idx_t [`CORE_WAYS-1:0] commit_idx;
	logic     [`CORE_WAYS-1:0] commit_en;
	logic stop;

	////////////////////
	// commit selection
	////////////////////
	always_comb begin
		commit_en     = '0;
		num_committed = '0;
		// nothing retires once a halt or illegal has gone out
		stop = error_status != NO_ERROR;
		for (int i = 0; i < `CORE_WAYS; i++) begin
			commit_idx[i] = head + rob_idx_t'(i);
			if (!stop && entry_done[commit_idx[i]]) begin
				commit_en[i]  = 1'b1;
				num_committed = num_committed + 1'b1;
				// a halt or illegal is the last commit
				if (entry_class[commit_idx[i]] != CLASS_NORMAL) begin
					stop = 1'b1;
				end
			end else begin
				// in order, first not-done entry blocks the rest
				stop = 1'b1;
			end
		end
	end

	// done bits and head pointer
	always_ff @(posedge clock) begin
		if (reset) begin
			entry_done <= '0;
			head       <= '0;
		end else begin
			head <= head + rob_idx_t'(num_committed);
			for (int i = 0; i < `CORE_WAYS; i++) begin
				if (commit_en[i]) begin
					entry_done[commit_idx[i]] <= 1'b0;
				end
			end
			// fresh entry waits for its result
			for (int i = 0; i < `CORE_WAYS; i++) begin
				if (disp_valid[i]) begin
					entry_done[disp_rob_idx[i]] <= 1'b0;
				end
			end
			for (int i = 0; i < `CORE_WAYS; i++) begin
				if (cdb_valid[i]) begin
					entry_done[cdb_rob_idx[i]] <= 1'b1;
				end
			end
		end
	end

	// entry payload, written at dispatch and at completion
	always_ff @(posedge clock) begin
		for (int i = 0; i < `CORE_WAYS; i++) begin
			if (disp_valid[i]) begin
				entry_dest[disp_rob_idx[i]] <= disp_dest[i];
				if (disp_op[i] == OP_HALT) begin
					entry_class[disp_rob_idx[i]] <= CLASS_HALT;
				end else if (disp_op[i] == OP_ILLEGAL) begin
					entry_class[disp_rob_idx[i]] <= CLASS_ILLEGAL;
				end else begin
					entry_class[disp_rob_idx[i]] <= CLASS_NORMAL;
				end
			end
			if (cdb_valid[i]) begin
				entry_result[cdb_rob_idx[i]] <= cdb_data[i];
			end
		end
	end

	////////////////////
	// commit outputs
	////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid    <= '0;
			commit_wr_en    <= '0;
			completed_insts <= '0;
		end else begin
			completed_insts <= num_committed;
			for (int i = 0; i < `CORE_WAYS; i++) begin
				commit_valid[i] <= commit_en[i];
				// r0 is never written, nor are halt or illegal
				commit_wr_en[i] <= commit_en[i] &&
					entry_class[commit_idx[i]] == CLASS_NORMAL &&
					entry_dest[commit_idx[i]] != '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `CORE_WAYS; i++) begin
			commit_reg[i]  <= entry_dest[commit_idx[i]];
			commit_data[i] <= entry_result[commit_idx[i]];
		end
	end

	// sticky status, set by the committing halt or illegal
	always_ff @(posedge clock) begin
		if (reset) begin
			error_status <= NO_ERROR;
		end else if (error_status == NO_ERROR) begin
			for (int i = 0; i < `CORE_WAYS; i++) begin
				if (commit_en[i] && entry_class[commit_idx[i]] == CLASS_ILLEGAL) begin
					error_status <= ILLEGAL_INST;
				end else if (commit_en[i] && entry_class[commit_idx[i]] == CLASS_HALT) begin
					error_status <= HALTED_ON_WFI;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== alu_lane.sv ====
////////////////////
// one ALU lane
// computes the slot result and drives one CDB lane a cycle later
////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "core_defs.svh"

module alu_lane (
	input  logic              clock,
	input  logic              reset,
	input  logic              disp_valid,
	input  isa_pkg::op_t      disp_op,
	input  isa_pkg::data_t    disp_a,
	input  isa_pkg::data_t    disp_b,
	input  rob_pkg::rob_idx_t disp_rob_idx,
	output logic              cdb_valid,
	output rob_pkg::rob_idx_t cdb_rob_idx,
	output isa_pkg::data_t    cdb_data
);
	import isa_pkg::*;
	import rob_pkg::*;

	data_t result;

	// op rules, halt and illegal give zero
	always_comb begin
		case (disp_op)
			OP_ADD:  result = disp_a + disp_b;
			OP_SUB:  result = disp_a - disp_b;
			OP_AND:  result = disp_a & disp_b;
			OP_OR:   result = disp_a | disp_b;
			OP_XOR:  result = disp_a ^ disp_b;
			// shift amount from low five bits only
			OP_SLL:  result = disp_a << disp_b[4:0];
			default: result = '0;
		endcase
	end

	////////////////////
	// CDB register
	////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= disp_valid;
		end
	end

	// tag travels with the result
	always_ff @(posedge clock) begin
		cdb_rob_idx <= disp_rob_idx;
		cdb_data    <= result;
	end

endmodule

`default_nettype wire

// ==== dispatch_stage.sv ====
////////////////////
// dispatch stage
// accepts front-end slots, hands out reorder-buffer indices,
// tracks free entries and raises stall
////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "core_defs.svh"

module dispatch_stage (
	input  logic                                     clock,
	input  logic                                     reset,
	input  logic          [`CORE_WAYS-1:0]           slot_valid,
	input  isa_pkg::op_t  [`CORE_WAYS-1:0]           slot_op,
	input  isa_pkg::data_t [`CORE_WAYS-1:0]          slot_a,
	input  isa_pkg::data_t [`CORE_WAYS-1:0]          slot_b,
	input  isa_pkg::reg_idx_t [`CORE_WAYS-1:0]       slot_dest,
	input  rob_pkg::commit_count_t                   num_committed,
	output logic                                     stall,
	output logic          [`CORE_WAYS-1:0]           disp_valid,
	output isa_pkg::op_t  [`CORE_WAYS-1:0]           disp_op,
	output isa_pkg::data_t [`CORE_WAYS-1:0]          disp_a,
	output isa_pkg::data_t [`CORE_WAYS-1:0]          disp_b,
	output isa_pkg::reg_idx_t [`CORE_WAYS-1:0]       disp_dest,
	output rob_pkg::rob_idx_t [`CORE_WAYS-1:0]       disp_rob_idx
);
	import isa_pkg::*;
	import rob_pkg::*;

	// next entry to hand out
	rob_idx_t tail;
	rob_count_t free_count;

	// index each slot would get this cycle
	rob_idx_t [`CORE_WAYS-1:0] slot_idx;
	// running count of valid slots, then total allocated
	commit_count_t offset;
	commit_count_t n_alloc;

	// full rule, not enough room for a whole group
	assign stall = free_count < `CORE_WAYS;

	////////////////////
	// index allocation
	////////////////////
	always_comb begin
		offset = '0;
		for (int i = 0; i < `CORE_WAYS; i++) begin
			// valid slots take consecutive entries in slot order
			slot_idx[i] = tail + rob_idx_t'(offset);
			if (slot_valid[i]) begin
				offset = offset + 1'b1;
			end
		end
		// nothing is taken while stalled
		n_alloc = stall ? '0 : offset;
	end

	// tail and free count, commits return entries on the same edge
	always_ff @(posedge clock) begin
		if (reset) begin
			tail       <= '0;
			free_count <= rob_count_t'(`ROB_DEPTH);
		end else begin
			tail       <= tail + rob_idx_t'(n_alloc);
			free_count <= free_count + rob_count_t'(num_committed) - rob_count_t'(n_alloc);
		end
	end

	////////////////////
	// slot register
	////////////////////
	always_ff @(posedge clock) begin
		if (reset || stall) begin
			// bubble while the front end holds its inputs
			disp_valid <= '0;
		end else begin
			disp_valid <= slot_valid;
		end
	end

	// payload follows the accepted slots
	always_ff @(posedge clock) begin
		if (!stall) begin
			disp_op      <= slot_op;
			disp_a       <= slot_a;
			disp_b       <= slot_b;
			disp_dest    <= slot_dest;
			disp_rob_idx <= slot_idx;
		end
	end

endmodule

`default_nettype wire

// ==== rob_pkg.sv ====
////////////////////
// reorder-buffer types
// indices, counts and commit status
////////////////////

`default_nettype none

`include "core_defs.svh"

package rob_pkg;

	// entry index, wraps modulo depth
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

	// free entries, 0 up to the full depth
	typedef logic [$clog2(`ROB_DEPTH):0] rob_count_t;

	// entries retired in one cycle, 0 up to the way count
	typedef logic [$clog2(`CORE_WAYS):0] commit_count_t;

	// sticky status reported after commit
	typedef enum logic [1:0] {
		NO_ERROR      = 2'd0,
		ILLEGAL_INST  = 2'd1,
		HALTED_ON_WFI = 2'd2
	} error_status_t;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
////////////////////
// instruction-level types
// operations, data words, register indices
////////////////////

`default_nettype none

`include "core_defs.svh"

package isa_pkg;

	// decoded operation carried by each slot
	typedef enum logic [3:0] {
		OP_ADD     = 4'h0,
		OP_SUB     = 4'h1,
		OP_AND     = 4'h2,
		OP_OR      = 4'h3,
		OP_XOR     = 4'h4,
		OP_SLL     = 4'h5,
		OP_HALT    = 4'he,
		OP_ILLEGAL = 4'hf
	} op_t;

	// operand and result word
	typedef logic [`DATA_W-1:0] data_t;

	// architectural destination index
	typedef logic [$clog2(`ARCH_REGS)-1:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== core_defs.svh ====
////////////////////
// core parameters shared by the dispatch-to-commit core
// ways, reorder-buffer depth, data width, register count
////////////////////

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// slots offered by the front end each cycle
`define CORE_WAYS 2

// reorder-buffer entries, power of two so indices wrap
`define ROB_DEPTH 4

// operand and result width
`define DATA_W 32

// architectural registers, r0 never written
`define ARCH_REGS 32

`endif
